/* Makefile */
# Verilator build and run of the memory subsystem testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench into $(LOG), check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert --top-module tb_rv_mem_subsys -f rv_mem_subsys.f -o tb_sim
	./obj_dir/tb_sim > $(LOG) 2>&1 || echo "TB FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "test passed"

clean:
	rm -rf obj_dir $(LOG)

/* bench/mem_checker.sv */
`timescale 1ns/1ps

module mem_checker (
    input  logic                   clk,
    input  logic                   i_arst_n,
    // stimulus as the DUT sees it
    input  logic                   i_fetch_en,
    input  logic                   i_redirect,
    input  rv_mem_pkg::byte_addr_t i_redirect_pc,
    input  logic                   i_mem_req_valid,
    input  rv_mem_pkg::mem_req_t   i_mem_req,
    // DUT responses
    input  logic                   i_instr_valid,
    input  rv_mem_pkg::word_t      i_instr,
    input  rv_mem_pkg::byte_addr_t i_instr_pc,
    input  logic                   i_load_valid,
    input  rv_mem_pkg::word_t      i_load_data,
    input  logic                   i_misaligned,
    // totals for the closing line
    output int                     o_errors,
    output int                     o_fetch_checks,
    output int                     o_load_checks,
    output int                     o_misaligned_checks
);

    // byte image of the ram, updated at each store edge
    logic [7:0] shadow [1 << rv_mem_pkg::BYTE_ADDR_W];

    // next sequential fetch address
    rv_mem_pkg::byte_addr_t pc_model;
    // fetch issued on the previous edge
    logic                   fetch_pend;
    rv_mem_pkg::byte_addr_t fetch_pc;
    rv_mem_pkg::word_t      fetch_word;
    // responses due in the current cycle
    logic                   load_pend;
    rv_mem_pkg::mem_op_e    load_op;
    rv_mem_pkg::byte_addr_t load_addr;
    rv_mem_pkg::word_t      load_word;
    logic                   mis_pend;

    int errors = 0;
    int fetch_checks = 0;
    int load_checks = 0;
    int mis_checks = 0;

    assign o_errors            = errors;
    assign o_fetch_checks      = fetch_checks;
    assign o_load_checks       = load_checks;
    assign o_misaligned_checks = mis_checks;

    task automatic report(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    // bytes touched by an access
    function automatic int access_size(input rv_mem_pkg::mem_op_e op);
        case (op)
            rv_mem_pkg::op_lb, rv_mem_pkg::op_lbu, rv_mem_pkg::op_sb: return 1;
            rv_mem_pkg::op_lh, rv_mem_pkg::op_lhu, rv_mem_pkg::op_sh: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic is_store(input rv_mem_pkg::mem_op_e op);
        return (op == rv_mem_pkg::op_sb) || (op == rv_mem_pkg::op_sh) ||
               (op == rv_mem_pkg::op_sw);
    endfunction

    // little endian word holding byte address a
    function automatic rv_mem_pkg::word_t shadow_word(input rv_mem_pkg::byte_addr_t a);
        rv_mem_pkg::byte_addr_t base;
        base = {a[rv_mem_pkg::BYTE_ADDR_W-1:2], 2'b00};
        return {shadow[base + 12'd3], shadow[base + 12'd2], shadow[base + 12'd1], shadow[base]};
    endfunction

    // expected load result, byte at a is the least significant one
    function automatic rv_mem_pkg::word_t ref_load(input rv_mem_pkg::mem_op_e op,
                                                   input rv_mem_pkg::byte_addr_t a);
        logic [7:0] lo;
        logic [7:0] hi;
        lo = shadow[a];
        hi = shadow[a + 12'd1];
        case (op)
            rv_mem_pkg::op_lb:  return {{24{lo[7]}}, lo};
            rv_mem_pkg::op_lbu: return {24'h000000, lo};
            rv_mem_pkg::op_lh:  return {{16{hi[7]}}, hi, lo};
            rv_mem_pkg::op_lhu: return {16'h0000, hi, lo};
            default:            return shadow_word(a);
        endcase
    endfunction

    always @(posedge clk) begin : compare
        rv_mem_pkg::byte_addr_t issue;
        int size;
        if (!i_arst_n) begin
            if (i_instr_valid !== 1'b0 || i_load_valid !== 1'b0 || i_misaligned !== 1'b0) begin
                report("a valid or misaligned output is not low during reset");
            end
            pc_model   = rv_mem_pkg::RESET_PC;
            fetch_pend = 1'b0;
            load_pend  = 1'b0;
            mis_pend   = 1'b0;
        end else begin
            // last edge's fetch shows up now unless a redirect drops it
            if (i_instr_valid !== (fetch_pend && !i_redirect)) begin
                report($sformatf("o_instr_valid is %b, expected %b",
                                 i_instr_valid, fetch_pend && !i_redirect));
            end else if (i_instr_valid) begin
                fetch_checks++;
                if (i_instr_pc !== fetch_pc || i_instr !== fetch_word) begin
                    report($sformatf("fetch got pc %h word %h, expected pc %h word %h",
                                     i_instr_pc, i_instr, fetch_pc, fetch_word));
                end
            end
            if (i_load_valid !== load_pend) begin
                report($sformatf("o_load_valid is %b, expected %b", i_load_valid, load_pend));
            end else if (load_pend) begin
                load_checks++;
                if (i_load_data !== load_word) begin
                    report($sformatf("%s at %h returned %h, expected %h",
                                     load_op.name(), load_addr, i_load_data, load_word));
                end
            end
            if (i_misaligned !== mis_pend) begin
                report($sformatf("o_misaligned is %b, expected %b", i_misaligned, mis_pend));
            end else if (mis_pend) begin
                mis_checks++;
            end

            // fetch on this edge sees memory before this edge's store
            fetch_pend = i_fetch_en;
            if (i_fetch_en) begin
                issue      = i_redirect ? i_redirect_pc : pc_model;
                fetch_pc   = issue;
                fetch_word = shadow_word(issue);
                pc_model   = issue + 12'd4;
            end else if (i_redirect) begin
                pc_model = i_redirect_pc;
            end

            load_pend = 1'b0;
            mis_pend  = 1'b0;
            if (i_mem_req_valid) begin
                size = access_size(i_mem_req.op);
                if ((int'(i_mem_req.addr) % size) != 0) begin
                    // flagged only, memory stays as it is
                    mis_pend = 1'b1;
                end else if (is_store(i_mem_req.op)) begin
                    for (int k = 0; k < size; k++) begin
                        shadow[i_mem_req.addr + rv_mem_pkg::byte_addr_t'(k)] =
                            i_mem_req.wdata[8*k +: 8];
                    end
                end else begin
                    load_pend = 1'b1;
                    load_op   = i_mem_req.op;
                    load_addr = i_mem_req.addr;
                    load_word = ref_load(i_mem_req.op, i_mem_req.addr);
                end
            end
        end
    end

endmodule

/* bench/tb_rv_mem_subsys.sv */
`timescale 1ns/1ps

module tb_rv_mem_subsys;

    localparam int PERIOD_NS    = 20;
    localparam int RESET_CYCLES = 5;
    localparam int FETCH_CYCLES = 40;
    localparam int SUB_STORES   = 120;
    localparam int SUB_LOADS    = 120;
    localparam int MIS_OPS      = 40;
    localparam int REDIRECTS    = 12;
    localparam int CONC_ROUNDS  = 8;
    // small window so sub-word loads hit recent stores
    localparam int SUB_BASE     = 'h300;
    // every phase at its longest, plus drain and margin
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + rv_mem_pkg::MEM_WORDS + FETCH_CYCLES
        + SUB_STORES + SUB_LOADS + 2 * MIS_OPS + 4 * REDIRECTS + 10 + 4 * CONC_ROUNDS + 100;

    logic                   clk = 1'b0;
    logic                   arst_n;
    logic                   fetch_en;
    logic                   redirect;
    rv_mem_pkg::byte_addr_t redirect_pc;
    logic                   mem_req_valid;
    rv_mem_pkg::mem_req_t   mem_req;
    logic                   instr_valid;
    rv_mem_pkg::word_t      instr;
    rv_mem_pkg::byte_addr_t instr_pc;
    logic                   load_valid;
    rv_mem_pkg::word_t      load_data;
    logic                   misaligned;

    int error_count;
    int fetch_checks;
    int load_checks;
    int misaligned_checks;

    // fetch enable level applied on every driven cycle
    logic        fetch_on;
    logic [31:0] lfsr_state = 32'hc2d1_46e2;

    always #(PERIOD_NS / 2) clk = ~clk;

    rv_mem_subsys uut (
        .clk             (clk),
        .i_arst_n        (arst_n),
        .i_fetch_en      (fetch_en),
        .i_redirect      (redirect),
        .i_redirect_pc   (redirect_pc),
        .i_mem_req_valid (mem_req_valid),
        .i_mem_req       (mem_req),
        .o_instr_valid   (instr_valid),
        .o_instr         (instr),
        .o_instr_pc      (instr_pc),
        .o_load_valid    (load_valid),
        .o_load_data     (load_data),
        .o_misaligned    (misaligned)
    );

    mem_checker u_checker (
        .clk                 (clk),
        .i_arst_n            (arst_n),
        .i_fetch_en          (fetch_en),
        .i_redirect          (redirect),
        .i_redirect_pc       (redirect_pc),
        .i_mem_req_valid     (mem_req_valid),
        .i_mem_req           (mem_req),
        .i_instr_valid       (instr_valid),
        .i_instr             (instr),
        .i_instr_pc          (instr_pc),
        .i_load_valid        (load_valid),
        .i_load_data         (load_data),
        .i_misaligned        (misaligned),
        .o_errors            (error_count),
        .o_fetch_checks      (fetch_checks),
        .o_load_checks       (load_checks),
        .o_misaligned_checks (misaligned_checks)
    );

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    function automatic rv_mem_pkg::word_t take_bits(input int n);
        rv_mem_pkg::word_t v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // random address in the sub-word window, aligned to the access size
    function automatic rv_mem_pkg::byte_addr_t sub_word_addr(input rv_mem_pkg::mem_op_e op);
        int off;
        off = int'(take_bits(6));
        if (op == rv_mem_pkg::op_sh || op == rv_mem_pkg::op_lh || op == rv_mem_pkg::op_lhu) begin
            off = off & ~1;
        end else if (op == rv_mem_pkg::op_sw || op == rv_mem_pkg::op_lw) begin
            off = off & ~3;
        end
        return rv_mem_pkg::byte_addr_t'(SUB_BASE + off);
    endfunction

    task automatic drive_cycle(input logic req_v, input rv_mem_pkg::mem_op_e op,
                               input rv_mem_pkg::byte_addr_t addr, input rv_mem_pkg::word_t wdata,
                               input logic redir, input rv_mem_pkg::byte_addr_t target);
        rv_mem_pkg::mem_req_t req;
        req.op    = op;
        req.addr  = addr;
        req.wdata = wdata;
        @(posedge clk);
        fetch_en      <= fetch_on;
        mem_req_valid <= req_v;
        mem_req       <= req;
        redirect      <= redir;
        redirect_pc   <= target;
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle(1'b0, rv_mem_pkg::op_lw, '0, '0, 1'b0, '0);
    endtask

    task automatic request(input rv_mem_pkg::mem_op_e op, input rv_mem_pkg::byte_addr_t addr,
                           input rv_mem_pkg::word_t wdata);
        drive_cycle(1'b1, op, addr, wdata, 1'b0, '0);
    endtask

    task automatic redirect_to(input rv_mem_pkg::byte_addr_t target);
        drive_cycle(1'b0, rv_mem_pkg::op_lw, '0, '0, 1'b1, target);
    endtask

    // redirect and a word store to the redirect target on the same edge
    task automatic redirect_with_store(input rv_mem_pkg::byte_addr_t target,
                                       input rv_mem_pkg::word_t wdata);
        drive_cycle(1'b1, rv_mem_pkg::op_sw, target, wdata, 1'b1, target);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * PERIOD_NS);
        $display("timeout: stimulus did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        rv_mem_pkg::mem_op_e    op;
        rv_mem_pkg::byte_addr_t a;
        rv_mem_pkg::byte_addr_t t;
        int                     gap;
        arst_n        = 1'b0;
        fetch_en      = 1'b0;
        redirect      = 1'b0;
        redirect_pc   = '0;
        mem_req_valid = 1'b0;
        mem_req       = '0;
        fetch_on      = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;

        // whole memory gets random words so every fetch has a known value
        for (int w = 0; w < rv_mem_pkg::MEM_WORDS; w++) begin
            request(rv_mem_pkg::op_sw, rv_mem_pkg::byte_addr_t'(w << 2), take_bits(32));
        end

        // sequential fetch from RESET_PC
        fetch_on = 1'b1;
        idle(FETCH_CYCLES);

        // sub-word stores, fetch keeps running alongside
        for (int i = 0; i < SUB_STORES; i++) begin
            case (take_bits(2))
                32'd0:   op = rv_mem_pkg::op_sb;
                32'd1:   op = rv_mem_pkg::op_sh;
                default: op = rv_mem_pkg::op_sw;
            endcase
            request(op, sub_word_addr(op), take_bits(32));
        end
        for (int i = 0; i < SUB_LOADS; i++) begin
            case (take_bits(3))
                32'd0:   op = rv_mem_pkg::op_lb;
                32'd1:   op = rv_mem_pkg::op_lh;
                32'd2:   op = rv_mem_pkg::op_lbu;
                32'd3:   op = rv_mem_pkg::op_lhu;
                default: op = rv_mem_pkg::op_lw;
            endcase
            request(op, sub_word_addr(op), '0);
        end

        // misaligned half and word requests, each followed by a word readback
        fetch_on = 1'b0;
        for (int i = 0; i < MIS_OPS; i++) begin
            case (take_bits(3))
                32'd0:   op = rv_mem_pkg::op_lh;
                32'd1:   op = rv_mem_pkg::op_lhu;
                32'd2:   op = rv_mem_pkg::op_sh;
                32'd3:   op = rv_mem_pkg::op_lw;
                default: op = rv_mem_pkg::op_sw;
            endcase
            a = rv_mem_pkg::byte_addr_t'(take_bits(12));
            if (op == rv_mem_pkg::op_lh || op == rv_mem_pkg::op_lhu || op == rv_mem_pkg::op_sh) begin
                a[0] = 1'b1;
            end else if (a[1:0] == 2'b00) begin
                a[1:0] = 2'b10;
            end
            request(op, a, take_bits(32));
            request(rv_mem_pkg::op_lw, {a[rv_mem_pkg::BYTE_ADDR_W-1:2], 2'b00}, '0);
        end

        // redirects with a fetch in flight, gaps of 0 to 3 cycles
        fetch_on = 1'b1;
        for (int i = 0; i < REDIRECTS; i++) begin
            gap = int'(take_bits(2));
            idle(gap);
            redirect_to(rv_mem_pkg::byte_addr_t'(take_bits(10) << 2));
        end
        // redirect while fetch is off only parks the pc
        fetch_on = 1'b0;
        idle(2);
        redirect_to(rv_mem_pkg::byte_addr_t'(take_bits(10) << 2));
        fetch_on = 1'b1;
        idle(6);

        // store into the word fetched on the same edge, then read both back
        for (int i = 0; i < CONC_ROUNDS; i++) begin
            t = rv_mem_pkg::byte_addr_t'(take_bits(10) << 2);
            redirect_with_store(t, take_bits(32));
            request(rv_mem_pkg::op_sw, t + 12'd4, take_bits(32));
            request(rv_mem_pkg::op_lw, t, '0);
            request(rv_mem_pkg::op_lw, t + 12'd4, '0);
        end

        fetch_on = 1'b0;
        idle(4);
        @(negedge clk);
        $display("checked %0d fetches, %0d loads, %0d misaligned flags; %0d errors",
                 fetch_checks, load_checks, misaligned_checks, error_count);
        if (error_count == 0 && fetch_checks > 0 && load_checks > 0 && misaligned_checks > 0) begin
            $display("TB PASSED");
        end else begin
            if (fetch_checks == 0 || load_checks == 0 || misaligned_checks == 0) begin
                $display("some kind of response was never seen by the checker");
            end
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* hdl/dual_port_ram.sv */
`timescale 1ns/1ps

module dual_port_ram (
    input  logic                   clk,
    // instruction port, read only
    input  rv_mem_pkg::word_addr_t i_if_addr,
    output rv_mem_pkg::word_t      o_if_data,
    // data port, read/write with byte enables
    input  logic                   i_en,
    input  rv_mem_pkg::byte_en_t   i_we,
    input  rv_mem_pkg::word_addr_t i_d_addr,
    input  rv_mem_pkg::word_t      i_wdata,
    output rv_mem_pkg::word_t      o_rdata
);

    // one byte wide array per lane
    // each lane is written only under its own enable bit
    for (genvar g_lane = 0; g_lane < rv_mem_pkg::NUM_LANES; g_lane++) begin : g_lane_mem
        logic [7:0] lane_mem [rv_mem_pkg::MEM_WORDS];
        logic [7:0] if_byte;
        logic [7:0] rd_byte;

        // data port write
        always_ff @(posedge clk) begin
            if (i_en && i_we[g_lane]) begin
                lane_mem[i_d_addr] <= i_wdata[8*g_lane +: 8];
            end
        end

        // instruction port reads every cycle
        // a write on the same edge is not seen, old byte comes out
        always_ff @(posedge clk) begin
            if_byte <= lane_mem[i_if_addr];
        end

        // data port read
        // output is forced to zero on idle cycles
        always_ff @(posedge clk) begin
            if (i_en) begin
                rd_byte <= lane_mem[i_d_addr];
            end else begin
                rd_byte <= '0;
            end
        end

        // place the lane bytes into the output words
        assign o_if_data[8*g_lane +: 8] = if_byte;
        assign o_rdata[8*g_lane +: 8]   = rd_byte;
    end

    // the load/store unit only raises byte enables on an enabled access
    a_we_needs_en : assert property (
        @(posedge clk) (i_we != '0) |-> i_en
    ) else $error("dual_port_ram: write enables set while i_en is low");

endmodule

/* hdl/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic                   clk,
    input  logic                   i_arst_n,
    input  logic                   i_fetch_en,
    input  logic                   i_redirect,
    input  rv_mem_pkg::byte_addr_t i_redirect_pc,
    // ram instruction port
    output rv_mem_pkg::word_addr_t o_if_addr,
    input  rv_mem_pkg::word_t      i_if_data,
    // fetched instruction
    output logic                   o_instr_valid,
    output rv_mem_pkg::word_t      o_instr,
    output rv_mem_pkg::byte_addr_t o_instr_pc
);

    // next pc to issue when no redirect arrives
    rv_mem_pkg::byte_addr_t pc;
    // address presented to the ram this cycle
    rv_mem_pkg::byte_addr_t issue_pc;
    // pc of the word now coming out of the ram
    rv_mem_pkg::byte_addr_t inflight_pc;
    logic                   inflight_valid;

    // redirect target bypasses the pc register
    // so the target is issued in the redirect cycle itself
    assign issue_pc  = i_redirect ? i_redirect_pc : pc;
    assign o_if_addr = issue_pc[rv_mem_pkg::BYTE_ADDR_W-1:2];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc             <= rv_mem_pkg::RESET_PC;
            inflight_valid <= 1'b0;
        end else begin
            // step past the issued word, or just park on the target
            if (i_fetch_en) begin
                pc <= issue_pc + rv_mem_pkg::PC_STEP;
            end else if (i_redirect) begin
                pc <= i_redirect_pc;
            end
            inflight_valid <= i_fetch_en;
        end
    end

    // tag travelling with the ram read
    always_ff @(posedge clk) begin
        inflight_pc <= issue_pc;
    end

    // the word issued before a redirect is on the old path
    // drop it in the redirect cycle so it is never reported
    assign o_instr_valid = inflight_valid && !i_redirect;
    assign o_instr       = i_if_data;
    assign o_instr_pc    = inflight_pc;

    // redirect targets come from aligned branch/jump results
    a_redirect_aligned : assert property (
        @(posedge clk) disable iff (!i_arst_n)
        i_redirect |-> (i_redirect_pc[1:0] == 2'b00)
    ) else $error("fetch_unit: unaligned redirect target");

    a_issue_aligned : assert property (
        @(posedge clk) disable iff (!i_arst_n)
        i_fetch_en |-> (issue_pc[1:0] == 2'b00)
    ) else $error("fetch_unit: unaligned fetch address");

endmodule

/* hdl/load_store_unit.sv */
`timescale 1ns/1ps

module load_store_unit (
    input  logic                   clk,
    input  logic                   i_arst_n,
    // request strobe from the core
    input  logic                   i_mem_req_valid,
    input  rv_mem_pkg::mem_req_t   i_mem_req,
    // ram data port
    output logic                   o_ram_en,
    output rv_mem_pkg::byte_en_t   o_ram_we,
    output rv_mem_pkg::word_addr_t o_ram_addr,
    output rv_mem_pkg::word_t      o_ram_wdata,
    input  rv_mem_pkg::word_t      i_ram_rdata,
    // responses
    output logic                   o_load_valid,
    output rv_mem_pkg::word_t      o_load_data,
    output logic                   o_misaligned
);

    // lanes covered by the access when placed at offset 0
    rv_mem_pkg::byte_en_t base_mask;
    logic                 req_store;
    logic [1:0]           req_off;
    logic                 req_misaligned;
    // aligned request that reaches the ram
    logic                 req_go;

    // load context held for the response cycle
    rv_mem_pkg::mem_op_e  load_op;
    logic [1:0]           load_off;
    // read word with the addressed byte moved to lane 0
    rv_mem_pkg::word_t    load_lane;

    assign req_off = i_mem_req.addr[1:0];

    // size and direction from the op
    always_comb begin
        base_mask = 4'b1111;
        req_store = 1'b0;
        case (i_mem_req.op)
            rv_mem_pkg::op_lb,
            rv_mem_pkg::op_lbu: base_mask = 4'b0001;
            rv_mem_pkg::op_lh,
            rv_mem_pkg::op_lhu: base_mask = 4'b0011;
            rv_mem_pkg::op_lw:  base_mask = 4'b1111;
            rv_mem_pkg::op_sb: begin
                base_mask = 4'b0001;
                req_store = 1'b1;
            end
            rv_mem_pkg::op_sh: begin
                base_mask = 4'b0011;
                req_store = 1'b1;
            end
            default: begin
                base_mask = 4'b1111;
                req_store = 1'b1;
            end
        endcase
    end

    // half and word need an even address
    // word also needs bit 1 clear
    assign req_misaligned = (base_mask[1] && req_off[0]) || (base_mask[2] && req_off[1]);
    assign req_go         = i_mem_req_valid && !req_misaligned;

    // ram side is driven straight from the request
    // a store lands on the edge that samples the strobe
    assign o_ram_en    = req_go;
    assign o_ram_addr  = i_mem_req.addr[rv_mem_pkg::BYTE_ADDR_W-1:2];
    assign o_ram_we    = (req_go && req_store) ? (base_mask << req_off) : '0;
    assign o_ram_wdata = i_mem_req.wdata << {req_off, 3'b000};

    // response strobes
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_load_valid <= 1'b0;
            o_misaligned <= 1'b0;
        end else begin
            o_load_valid <= req_go && !req_store;
            o_misaligned <= i_mem_req_valid && req_misaligned;
        end
    end

    // op and byte offset follow the read into the next cycle
    always_ff @(posedge clk) begin
        if (req_go && !req_store) begin
            load_op  <= i_mem_req.op;
            load_off <= req_off;
        end
    end

    // pick the lane from the registered ram word
    assign load_lane = i_ram_rdata >> {load_off, 3'b000};

    // sign or zero extension by op
    always_comb begin
        case (load_op)
            rv_mem_pkg::op_lb:  o_load_data = {{24{load_lane[7]}}, load_lane[7:0]};
            rv_mem_pkg::op_lh:  o_load_data = {{16{load_lane[15]}}, load_lane[15:0]};
            rv_mem_pkg::op_lbu: o_load_data = {24'h000000, load_lane[7:0]};
            rv_mem_pkg::op_lhu: o_load_data = {16'h0000, load_lane[15:0]};
            // lw, offset is always zero here
            default:            o_load_data = load_lane;
        endcase
    end

    // one request per cycle gives exactly one kind of response
    a_one_response : assert property (
        @(posedge clk) disable iff (!i_arst_n)
        !(o_load_valid && o_misaligned)
    ) else $error("load_store_unit: load response and misaligned flag together");

endmodule

/* hdl/rv_mem_pkg.sv */
package rv_mem_pkg;

    // data path width of the core
    localparam int XLEN = 32;

    // one write enable per byte of a word
    localparam int NUM_LANES = XLEN / 8;

    // 4 KiB of byte addressable memory
    localparam int BYTE_ADDR_W = 12;

    // word index drops the two byte offset bits
    localparam int WORD_ADDR_W = BYTE_ADDR_W - 2;

    // number of words held by each ram lane
    localparam int MEM_WORDS = 1 << WORD_ADDR_W;

    // one data word
    typedef logic [XLEN-1:0] word_t;

    // byte address as seen by fetch and load/store
    typedef logic [BYTE_ADDR_W-1:0] byte_addr_t;

    // word index into the ram
    typedef logic [WORD_ADDR_W-1:0] word_addr_t;

    // byte lane write enables, bit 0 is the lowest byte
    typedef logic [NUM_LANES-1:0] byte_en_t;

    // first address fetched after reset
    localparam byte_addr_t RESET_PC = '0;

    // sequential fetch advances one word per cycle
    localparam byte_addr_t PC_STEP = byte_addr_t'(4);

    // memory operation code
    // loads first, then stores
    typedef enum logic [2:0] {
        op_lb  = 3'd0,
        op_lh  = 3'd1,
        op_lw  = 3'd2,
        op_lbu = 3'd3,
        op_lhu = 3'd4,
        op_sb  = 3'd5,
        op_sh  = 3'd6,
        op_sw  = 3'd7
    } mem_op_e;

    // load/store request presented with the strobe
    // wdata is only meaningful for stores
    // and is kept in the low bytes, unshifted
    typedef struct packed {
        mem_op_e    op;
        byte_addr_t addr;
        word_t      wdata;
    } mem_req_t;

endpackage

/* hdl/rv_mem_subsys.sv */
`timescale 1ns/1ps

module rv_mem_subsys (
    input  logic                   clk,
    input  logic                   i_arst_n,
    // fetch control
    input  logic                   i_fetch_en,
    input  logic                   i_redirect,
    input  rv_mem_pkg::byte_addr_t i_redirect_pc,
    // load/store request
    input  logic                   i_mem_req_valid,
    input  rv_mem_pkg::mem_req_t   i_mem_req,
    // instruction stream
    output logic                   o_instr_valid,
    output rv_mem_pkg::word_t      o_instr,
    output rv_mem_pkg::byte_addr_t o_instr_pc,
    // load/store responses
    output logic                   o_load_valid,
    output rv_mem_pkg::word_t      o_load_data,
    output logic                   o_misaligned
);

    // instruction port
    rv_mem_pkg::word_addr_t if_addr;
    rv_mem_pkg::word_t      if_data;

    // data port
    logic                   ram_en;
    rv_mem_pkg::byte_en_t   ram_we;
    rv_mem_pkg::word_addr_t ram_addr;
    rv_mem_pkg::word_t      ram_wdata;
    rv_mem_pkg::word_t      ram_rdata;

    fetch_unit u_fetch (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_fetch_en    (i_fetch_en),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .o_if_addr     (if_addr),
        .i_if_data     (if_data),
        .o_instr_valid (o_instr_valid),
        .o_instr       (o_instr),
        .o_instr_pc    (o_instr_pc)
    );

    load_store_unit u_lsu (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_mem_req_valid (i_mem_req_valid),
        .i_mem_req       (i_mem_req),
        .o_ram_en        (ram_en),
        .o_ram_we        (ram_we),
        .o_ram_addr      (ram_addr),
        .o_ram_wdata     (ram_wdata),
        .i_ram_rdata     (ram_rdata),
        .o_load_valid    (o_load_valid),
        .o_load_data     (o_load_data),
        .o_misaligned    (o_misaligned)
    );

    // shared memory, fetch on one port and load/store on the other
    dual_port_ram u_ram (
        .clk       (clk),
        .i_if_addr (if_addr),
        .o_if_data (if_data),
        .i_en      (ram_en),
        .i_we      (ram_we),
        .i_d_addr  (ram_addr),
        .i_wdata   (ram_wdata),
        .o_rdata   (ram_rdata)
    );

endmodule

/* rv_mem_subsys.f */
hdl/rv_mem_pkg.sv
hdl/dual_port_ram.sv
hdl/fetch_unit.sv
hdl/load_store_unit.sv
hdl/rv_mem_subsys.sv
bench/mem_checker.sv
bench/tb_rv_mem_subsys.sv
